/* all.f */
rtl/desc_hub_pkg.sv
rtl/desc_fifo.sv
rtl/core_desc_router.sv
rtl/sched_ctrl_parser.sv
rtl/send_arbiter.sv
rtl/ctrl_out_arbiter.sv
rtl/bc_msg_unit.sv
rtl/core_desc_hub.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

/* dv/tb_checker.sv */
//////////////////////////////
// Descriptor hub checker
// Reference queues and slot table, compares DUT outputs
//////////////////////////////
`default_nettype none

module tb_checker #(
  parameter int          SLOT_COUNT     = 8,
  parameter logic [15:0] SLOT_BASE_ADDR = 16'h0,
  parameter logic [15:0] SLOT_ADDR_STEP = 16'h0800
) (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  desc_hub_pkg::core_id_t   core_id,
  input  desc_hub_pkg::desc_t      out_desc,
  input  logic                     out_desc_valid,
  input  logic                     out_desc_ready,
  input  desc_hub_pkg::ctrl_msg_t  ctrl_s,
  input  logic                     ctrl_s_valid,
  input  logic                     ctrl_s_ready,
  input  desc_hub_pkg::desc_t      send_desc,
  input  logic                     send_desc_valid,
  input  logic                     send_desc_ready,
  input  logic                     pkt_sent,
  input  desc_hub_pkg::ctrl_msg_t  ctrl_m,
  input  logic                     ctrl_m_valid,
  input  logic                     ctrl_m_ready,
  input  logic                     core_reset,
  input  desc_hub_pkg::bc_msg_t    core_msg_in,
  input  desc_hub_pkg::core_id_t   core_msg_in_user,
  input  logic                     core_msg_in_valid,
  input  desc_hub_pkg::bc_msg_t    bc_msg_in,
  input  desc_hub_pkg::core_id_t   bc_msg_in_user,
  input  logic                     bc_msg_in_valid,
  input  desc_hub_pkg::bc_msg_t    bc_msg_out,
  input  logic                     bc_msg_out_valid,
  input  logic                     bc_msg_out_ready,
  input  desc_hub_pkg::bc_msg_t    core_msg_out,
  input  logic                     core_msg_out_valid,
  input  logic                     core_msg_out_ready,
  output logic                     drained
);

  import desc_hub_pkg::*;

  string       cur_test = "none";
  int          test_count;
  int          check_count;
  int          err_count;
  int          test_checks;
  int          test_errs;

  desc_t       exp_core_send [$];
  desc_t       exp_sched_send [$];
  ctrl_msg_t   exp_release [$];
  ctrl_msg_t   exp_core_ctrl [$];
  bc_msg_t     exp_msg_out [$];
  logic [15:0] slot_addr_model [SLOT_COUNT];

  logic        model_rst;
  logic        in_flight;
  desc_t       last_sent;
  desc_t       exp_d;
  ctrl_msg_t   exp_c;
  bc_msg_t     exp_m;
  logic        prev_valid;
  bc_msg_t     prev_msg;
  core_id_t    prev_user;

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    test_count++;
    $display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errs);
  endtask

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    check_count++;
    test_checks++;
    if (exp !== act) begin
      err_count++;
      test_errs++;
      $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_problem(input string what);
    err_count++;
    test_errs++;
    $display("%s: %s", cur_test, what);
  endtask

  // Scheduler message turned into a send descriptor
  function automatic desc_t sched_desc(input ctrl_msg_t m);
    desc_t d;
    d           = '0;
    d.desc_type = DESC_SEND;
    d.addr      = slot_addr_model[m.tag[SLOT_W-1:0]];
    d.port      = m.port;
    d.tag       = m.tag;
    d.len       = m.len;
    return d;
  endfunction

  function automatic ctrl_msg_t ctrl_word(input logic [3:0] t, input desc_t d);
    ctrl_msg_t w;
    w.msg_type = t;
    w.port     = d.port;
    w.tag      = d.tag;
    w.len      = d.len;
    return w;
  endfunction

  // Everything sampled mid-cycle, a handshake here moves on the next rising edge
  always @(negedge sys_clk) begin
    if (sys_rst) begin
      model_rst  = 1'b1;
      in_flight  = 1'b0;
      prev_valid = 1'b0;
      drained    = 1'b1;
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slot_addr_model[i] = 16'(SLOT_BASE_ADDR + i * SLOT_ADDR_STEP);
      end
    end else begin
      compare("core_reset", 64'(model_rst), 64'(core_reset));
      if (core_reset && out_desc_ready) begin
        report_problem("out_desc_ready is high while the core is held in reset");
      end

      ////////////////////////////////
      // Inputs feeding the model
      ////////////////////////////////
      if (ctrl_s_valid && ctrl_s_ready) begin
        if (ctrl_s.msg_type == CTRL_RESET_TYPE) model_rst = ctrl_s.len[0];
        else if (!model_rst) exp_sched_send.push_back(sched_desc(ctrl_s));
      end
      if (out_desc_valid && out_desc_ready) begin
        case (out_desc.desc_type)
          DESC_SEND: exp_core_send.push_back(out_desc);
          DESC_SLOT_FREE, DESC_SLOT_BUSY, DESC_CORE_MSG: begin
            exp_core_ctrl.push_back(ctrl_word(out_desc.desc_type, out_desc));
            slot_addr_model[out_desc.tag[SLOT_W-1:0]] = out_desc.addr;
          end
          default: ;
        endcase
      end
      if (bc_msg_out_valid && bc_msg_out_ready) exp_msg_out.push_back(bc_msg_out);

      ////////////////////////////////
      // Output comparisons
      ////////////////////////////////
      if (send_desc_valid && send_desc_ready) begin
        if (send_desc.desc_type != 4'd0) report_problem("send_desc carries a non-send opcode");
        // Core sends are the only ones with a nonzero rsvd
        if (send_desc.rsvd != '0 && exp_core_send.size() == 0) begin
          report_problem("send_desc shows a core send that was never issued");
        end else if (send_desc.rsvd == '0 && exp_sched_send.size() == 0) begin
          report_problem("send_desc shows a scheduler send that was never issued");
        end else begin
          exp_d = (send_desc.rsvd != '0) ? exp_core_send.pop_front() : exp_sched_send.pop_front();
          compare("send_desc", exp_d, send_desc);
          last_sent = exp_d;
          in_flight = 1'b1;
        end
      end
      if (pkt_sent) begin
        exp_release.push_back(ctrl_word(4'h0, last_sent));
        in_flight = 1'b0;
      end

      if (ctrl_m_valid && ctrl_m_ready) begin
        if (ctrl_m.msg_type > 4'd3) begin
          report_problem("ctrl_m carries an opcode that should have been dropped");
        end else if (ctrl_m.msg_type == 4'd0 && exp_release.size() == 0) begin
          report_problem("ctrl_m shows a release with no packet sent");
        end else if (ctrl_m.msg_type != 4'd0 && exp_core_ctrl.size() == 0) begin
          report_problem("ctrl_m shows a control word that the core never issued");
        end else begin
          exp_c = (ctrl_m.msg_type == 4'd0) ? exp_release.pop_front() : exp_core_ctrl.pop_front();
          compare("ctrl_m", 64'(exp_c), 64'(ctrl_m));
        end
      end

      // Broadcast in, one cycle behind with own id masked
      compare("bc_msg_in_valid", 64'(prev_valid && (prev_user != core_id)),
              64'(bc_msg_in_valid));
      if (prev_valid && (prev_user != core_id)) begin
        compare("bc_msg_in", 64'(prev_msg), 64'(bc_msg_in));
        compare("bc_msg_in_user", 64'(prev_user), 64'(bc_msg_in_user));
      end
      prev_valid = core_msg_in_valid;
      prev_msg   = core_msg_in;
      prev_user  = core_msg_in_user;

      if (core_msg_out_valid && core_msg_out_ready) begin
        if (exp_msg_out.size() == 0) begin
          report_problem("core_msg_out delivered a message that was never queued");
        end else begin
          exp_m = exp_msg_out.pop_front();
          compare("core_msg_out", 64'(exp_m), 64'(core_msg_out));
        end
      end

      drained = (exp_core_send.size() == 0) && (exp_sched_send.size() == 0) &&
                (exp_release.size() == 0) && (exp_core_ctrl.size() == 0) &&
                (exp_msg_out.size() == 0) && !in_flight;
    end
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 5
) (
  output logic sys_clk,
  output logic sys_rst
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD / 2) sys_clk = ~sys_clk;
  end

  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge sys_clk);
    sys_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
//////////////////////////////
// Descriptor hub testbench top
// LFSR stimulus, test sequence and watchdog
//////////////////////////////
`default_nettype none

module tb_top;

  import desc_hub_pkg::*;

  localparam int          CLK_PERIOD     = 100;
  localparam logic [15:0] SLOT_BASE_ADDR = 16'h0;
  localparam logic [15:0] SLOT_ADDR_STEP = 16'h0800;
  localparam core_id_t    OWN_ID         = 4'h2;

  // Items per test
  localparam int N_RST   = 8;
  localparam int N_CORE  = 40;
  localparam int N_SCHED = 30;
  localparam int N_CTRL  = 30;
  localparam int N_MIX   = 20;
  localparam int N_BC    = 40;
  localparam int N_ITEMS = N_RST + N_CORE + 2 * N_SCHED + N_CTRL + 2 * N_MIX + N_BC;
  // Worst case per item is a few ready stalls plus the pkt_sent delay
  localparam int TIMEOUT_CYCLES = 4 * 16 * N_ITEMS + 200;

  logic      sys_clk, sys_rst;
  core_id_t  core_id;
  desc_t     out_desc, send_desc;
  logic      out_desc_valid, out_desc_ready;
  ctrl_msg_t ctrl_s, ctrl_m;
  logic      ctrl_s_valid, ctrl_s_ready, ctrl_m_valid;
  logic      ctrl_m_ready = 1'b0;
  logic      send_desc_valid, core_reset;
  logic      send_desc_ready = 1'b0;
  logic      pkt_sent = 1'b0;
  bc_msg_t   core_msg_in, bc_msg_in, bc_msg_out, core_msg_out;
  core_id_t  core_msg_in_user, bc_msg_in_user;
  logic      core_msg_in_valid, bc_msg_in_valid;
  logic      bc_msg_out_valid, bc_msg_out_ready;
  logic      core_msg_out_valid;
  logic      core_msg_out_ready = 1'b0;
  logic      drained;

  logic [31:0] lfsr_state;
  logic        send_fire;
  logic [1:0]  sent_wait;
  logic [1:0]  sent_delay;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(5)) u_clk (.sys_clk, .sys_rst);

  core_desc_hub #(
    .SLOT_BASE_ADDR (SLOT_BASE_ADDR),
    .SLOT_ADDR_STEP (SLOT_ADDR_STEP)
  ) dut (.*);

  tb_checker #(
    .SLOT_BASE_ADDR (SLOT_BASE_ADDR),
    .SLOT_ADDR_STEP (SLOT_ADDR_STEP)
  ) u_chk (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i]       = lfsr_state[0];
    end
    return v;
  endfunction

  function automatic desc_t random_desc(input logic [3:0] t);
    desc_t d;
    d.desc_type = t;
    d.rsvd      = 12'(rand_bits(12)) | 12'h001;
    d.addr      = 16'(rand_bits(16));
    d.port      = 8'(rand_bits(8));
    d.tag       = 8'(rand_bits(8));
    d.len       = 16'(rand_bits(16));
    return d;
  endfunction

  function automatic ctrl_msg_t random_msg();
    ctrl_msg_t m;
    m.msg_type = 4'(rand_bits(3));
    m.port     = 8'(rand_bits(8));
    m.tag      = 8'(rand_bits(8));
    m.len      = 16'(rand_bits(16));
    return m;
  endfunction

  task automatic put_out_desc(input desc_t d);
    @(posedge sys_clk);
    out_desc       <= d;
    out_desc_valid <= 1'b1;
    @(negedge sys_clk);
    while (!out_desc_ready) @(negedge sys_clk);
    @(posedge sys_clk);
    out_desc_valid <= 1'b0;
  endtask

  task automatic put_ctrl_s(input ctrl_msg_t m);
    @(posedge sys_clk);
    ctrl_s       <= m;
    ctrl_s_valid <= 1'b1;
    @(negedge sys_clk);
    while (!ctrl_s_ready) @(negedge sys_clk);
    @(posedge sys_clk);
    ctrl_s_valid <= 1'b0;
  endtask

  task automatic put_bc_msg(input bc_msg_t m);
    @(posedge sys_clk);
    bc_msg_out       <= m;
    bc_msg_out_valid <= 1'b1;
    @(negedge sys_clk);
    while (!bc_msg_out_ready) @(negedge sys_clk);
    @(posedge sys_clk);
    bc_msg_out_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    do @(posedge sys_clk); while (!drained);
  endtask

  ////////////////////////////////
  // Random ready and pkt_sent
  ////////////////////////////////
  always @(negedge sys_clk) send_fire = send_desc_valid && send_desc_ready;

  always @(posedge sys_clk) begin
    if (sys_rst) begin
      send_desc_ready    <= 1'b0;
      ctrl_m_ready       <= 1'b0;
      core_msg_out_ready <= 1'b0;
      pkt_sent           <= 1'b0;
      sent_wait          <= 2'd0;
    end else begin
      send_desc_ready    <= |rand_bits(2);
      ctrl_m_ready       <= |rand_bits(2);
      core_msg_out_ready <= |rand_bits(2);
      pkt_sent           <= 1'b0;
      // Completion comes 0 to 3 cycles after acceptance
      if (send_fire) begin
        sent_delay = 2'(rand_bits(2));
        if (sent_delay == 2'd0) pkt_sent <= 1'b1;
        else                    sent_wait <= sent_delay;
      end else if (sent_wait != 2'd0) begin
        sent_wait <= sent_wait - 2'd1;
        if (sent_wait == 2'd1) pkt_sent <= 1'b1;
      end
    end
  end

  initial begin
    ctrl_msg_t m;
    logic [3:0] t;
    lfsr_state        = 32'hcb33_f6b9;
    send_fire         = 1'b0;
    core_id           = OWN_ID;
    out_desc          = '0;
    out_desc_valid    = 1'b0;
    ctrl_s            = '0;
    ctrl_s_valid      = 1'b0;
    core_msg_in       = '0;
    core_msg_in_user  = '0;
    core_msg_in_valid = 1'b0;
    bc_msg_out        = '0;
    bc_msg_out_valid  = 1'b0;
    wait (!sys_rst);

    // A plain message while in reset is dropped, then reset commands
    u_chk.start_test("reset_cmd");
    put_ctrl_s(random_msg());
    for (int i = 0; i < N_RST; i++) begin
      m          = random_msg();
      m.msg_type = CTRL_RESET_TYPE;
      m.len      = (i == N_RST - 1) ? 16'h0 : 16'(rand_bits(16));
      put_ctrl_s(m);
    end
    wait_drained();
    u_chk.end_test();

    u_chk.start_test("core_send");
    for (int i = 0; i < N_CORE; i++) begin
      t = 4'(rand_bits(4));
      if (t < 4'd4) t = t + 4'd4;
      put_out_desc(random_desc((|rand_bits(2)) ? 4'd0 : t));
    end
    wait_drained();
    u_chk.end_test();

    u_chk.start_test("sched_default");
    repeat (N_SCHED) put_ctrl_s(random_msg());
    wait_drained();
    u_chk.end_test();

    // Control words rewrite slots, interleaved with core sends
    u_chk.start_test("core_ctrl");
    repeat (N_CTRL) put_out_desc(random_desc(4'(rand_bits(2))));
    wait_drained();
    u_chk.end_test();

    u_chk.start_test("sched_table");
    repeat (N_SCHED) put_ctrl_s(random_msg());
    wait_drained();
    u_chk.end_test();

    u_chk.start_test("mixed_send");
    fork
      repeat (N_MIX) put_out_desc(random_desc(4'd0));
      repeat (N_MIX) put_ctrl_s(random_msg());
    join
    wait_drained();
    u_chk.end_test();

    u_chk.start_test("broadcast");
    fork
      begin
        repeat (N_BC) begin
          @(posedge sys_clk);
          core_msg_in       <= 46'(rand_bits(46));
          core_msg_in_user  <= 4'(rand_bits(2));
          core_msg_in_valid <= 1'(rand_bits(1));
        end
        @(posedge sys_clk);
        core_msg_in_valid <= 1'b0;
      end
      repeat (N_BC / 2) put_bc_msg(46'(rand_bits(46)));
    join
    repeat (2) @(posedge sys_clk);
    wait_drained();
    u_chk.end_test();

    $display("tests %0d, checks %0d, errors %0d",
             u_chk.test_count, u_chk.check_count, u_chk.err_count);
    if (u_chk.err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("run stopped after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/bc_msg_unit.sv */
//////////////////////////////
// Broadcast message unit
// Own-id filter and outgoing queue
//////////////////////////////
`default_nettype none

module bc_msg_unit #(
  parameter int MSG_DEPTH = 16
) (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  logic                     core_reset,
  input  desc_hub_pkg::core_id_t   core_id,
  input  desc_hub_pkg::bc_msg_t    core_msg_in,
  input  desc_hub_pkg::core_id_t   core_msg_in_user,
  input  logic                     core_msg_in_valid,
  output desc_hub_pkg::bc_msg_t    bc_msg_in,
  output desc_hub_pkg::core_id_t   bc_msg_in_user,
  output logic                     bc_msg_in_valid,
  input  desc_hub_pkg::bc_msg_t    bc_msg_out,
  input  logic                     bc_msg_out_valid,
  output logic                     bc_msg_out_ready,
  output desc_hub_pkg::bc_msg_t    core_msg_out,
  output logic                     core_msg_out_valid,
  input  logic                     core_msg_out_ready
);

  import desc_hub_pkg::*;

  logic q_ready;

  always_ff @(posedge sys_clk) begin
    bc_msg_in      <= core_msg_in;
    bc_msg_in_user <= core_msg_in_user;
    // A core never hears its own broadcast
    if (sys_rst) bc_msg_in_valid <= 1'b0;
    else         bc_msg_in_valid <= core_msg_in_valid && (core_msg_in_user != core_id);
  end

  assign bc_msg_out_ready = q_ready && !core_reset;

  desc_fifo #(.DEPTH(MSG_DEPTH), .WIDTH($bits(bc_msg_t))) u_msg_q (
    .sys_clk, .sys_rst,
    .clear      (core_reset),
    .din        (bc_msg_out),
    .din_valid  (bc_msg_out_valid && !core_reset),
    .din_ready  (q_ready),
    .dout       (core_msg_out),
    .dout_valid (core_msg_out_valid),
    .dout_ready (core_msg_out_ready)
  );

endmodule

`default_nettype wire

/* rtl/core_desc_hub.sv */
//////////////////////////////
// Descriptor hub top level
//////////////////////////////
`default_nettype none

module core_desc_hub #(
  parameter int          SLOT_COUNT     = 8,
  parameter logic [15:0] SLOT_BASE_ADDR = 16'h0,
  parameter logic [15:0] SLOT_ADDR_STEP = 16'h0800,
  parameter int          SEND_DEPTH     = 8,
  parameter int          CTRL_DEPTH     = 8,
  parameter int          MSG_DEPTH      = 16
) (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  desc_hub_pkg::core_id_t   core_id,
  // Core descriptors
  input  desc_hub_pkg::desc_t      out_desc,
  input  logic                     out_desc_valid,
  output logic                     out_desc_ready,
  // Scheduler in and out
  input  desc_hub_pkg::ctrl_msg_t  ctrl_s,
  input  logic                     ctrl_s_valid,
  output logic                     ctrl_s_ready,
  output desc_hub_pkg::ctrl_msg_t  ctrl_m,
  output logic                     ctrl_m_valid,
  input  logic                     ctrl_m_ready,
  // Transmitter
  output desc_hub_pkg::desc_t      send_desc,
  output logic                     send_desc_valid,
  input  logic                     send_desc_ready,
  input  logic                     pkt_sent,
  output logic                     core_reset,
  // Broadcast messages
  input  desc_hub_pkg::bc_msg_t    core_msg_in,
  input  desc_hub_pkg::core_id_t   core_msg_in_user,
  input  logic                     core_msg_in_valid,
  output desc_hub_pkg::bc_msg_t    bc_msg_in,
  output desc_hub_pkg::core_id_t   bc_msg_in_user,
  output logic                     bc_msg_in_valid,
  input  desc_hub_pkg::bc_msg_t    bc_msg_out,
  input  logic                     bc_msg_out_valid,
  output logic                     bc_msg_out_ready,
  output desc_hub_pkg::bc_msg_t    core_msg_out,
  output logic                     core_msg_out_valid,
  input  logic                     core_msg_out_ready
);

  import desc_hub_pkg::*;

  desc_t     core_send, core_ctrl, sched_send, released;
  logic      core_send_valid, core_send_ready;
  logic      core_ctrl_valid, core_ctrl_ready;
  logic      sched_send_valid, sched_send_ready;
  logic      released_valid, released_ready;
  slot_upd_t slot_upd;

  core_desc_router #(.SEND_DEPTH(SEND_DEPTH), .CTRL_DEPTH(CTRL_DEPTH)) u_router (.*);

  sched_ctrl_parser #(
    .SLOT_COUNT     (SLOT_COUNT),
    .SLOT_BASE_ADDR (SLOT_BASE_ADDR),
    .SLOT_ADDR_STEP (SLOT_ADDR_STEP),
    .SEND_DEPTH     (SEND_DEPTH)
  ) u_parser (.*);

  send_arbiter #(.CTRL_DEPTH(CTRL_DEPTH)) u_send_arb (.*);

  ctrl_out_arbiter u_ctrl_arb (.*);

  bc_msg_unit #(.MSG_DEPTH(MSG_DEPTH)) u_bc (.*);

endmodule

`default_nettype wire

/* rtl/core_desc_router.sv */
//////////////////////////////
// Core descriptor router
// Splits core descriptors by opcode into send and control queues
//////////////////////////////
`default_nettype none

module core_desc_router #(
  parameter int SEND_DEPTH = 8,
  parameter int CTRL_DEPTH = 8
) (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  logic                     core_reset,
  input  desc_hub_pkg::desc_t      out_desc,
  input  logic                     out_desc_valid,
  output logic                     out_desc_ready,
  output desc_hub_pkg::desc_t      core_send,
  output logic                     core_send_valid,
  input  logic                     core_send_ready,
  output desc_hub_pkg::desc_t      core_ctrl,
  output logic                     core_ctrl_valid,
  input  logic                     core_ctrl_ready,
  output desc_hub_pkg::slot_upd_t  slot_upd
);

  import desc_hub_pkg::*;

  logic is_send;
  logic is_ctrl;
  logic send_q_ready;
  logic ctrl_q_ready;

  // Opcode decode
  always_comb begin
    is_send = 1'b0;
    is_ctrl = 1'b0;
    case (desc_type_e'(out_desc.desc_type))
      DESC_SEND:                                    is_send = 1'b1;
      DESC_SLOT_FREE, DESC_SLOT_BUSY, DESC_CORE_MSG: is_ctrl = 1'b1;
      default:                                      ;
    endcase
  end

  // Unknown opcodes are taken and dropped
  assign out_desc_ready = !core_reset &&
                          (is_send ? send_q_ready : (is_ctrl ? ctrl_q_ready : 1'b1));

  // Every accepted control descriptor also updates the slot table
  assign slot_upd.valid = out_desc_valid && out_desc_ready && is_ctrl;
  assign slot_upd.slot  = out_desc.tag[SLOT_W-1:0];
  assign slot_upd.addr  = out_desc.addr;
  assign slot_upd.len   = out_desc.len;

  desc_fifo #(.DEPTH(SEND_DEPTH), .WIDTH($bits(desc_t))) u_send_q (
    .sys_clk, .sys_rst,
    .clear      (core_reset),
    .din        (out_desc),
    .din_valid  (out_desc_valid && is_send && !core_reset),
    .din_ready  (send_q_ready),
    .dout       (core_send),
    .dout_valid (core_send_valid),
    .dout_ready (core_send_ready)
  );

  desc_fifo #(.DEPTH(CTRL_DEPTH), .WIDTH($bits(desc_t))) u_ctrl_q (
    .sys_clk, .sys_rst,
    .clear      (core_reset),
    .din        (out_desc),
    .din_valid  (out_desc_valid && is_ctrl && !core_reset),
    .din_ready  (ctrl_q_ready),
    .dout       (core_ctrl),
    .dout_valid (core_ctrl_valid),
    .dout_ready (core_ctrl_ready)
  );

endmodule

`default_nettype wire

/* rtl/ctrl_out_arbiter.sv */
//////////////////////////////
// Control output arbiter
// Releases first, then core control, into the ctrl_m register
//////////////////////////////
`default_nettype none

module ctrl_out_arbiter (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  desc_hub_pkg::desc_t      released,
  input  logic                     released_valid,
  output logic                     released_ready,
  input  desc_hub_pkg::desc_t      core_ctrl,
  input  logic                     core_ctrl_valid,
  output logic                     core_ctrl_ready,
  output desc_hub_pkg::ctrl_msg_t  ctrl_m,
  output logic                     ctrl_m_valid,
  input  logic                     ctrl_m_ready
);

  import desc_hub_pkg::*;

  desc_t win;
  logic  load_en;

  assign win             = released_valid ? released : core_ctrl;
  assign load_en         = !ctrl_m_valid || ctrl_m_ready;
  assign released_ready  = load_en;
  assign core_ctrl_ready = load_en && !released_valid;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      ctrl_m_valid <= 1'b0;
    end else if (load_en) begin
      ctrl_m_valid <= released_valid || core_ctrl_valid;
    end
  end

  // Type plus the low 32 bits of the descriptor
  always_ff @(posedge sys_clk) begin
    if (load_en && (released_valid || core_ctrl_valid)) begin
      ctrl_m <= {win.desc_type, win.port, win.tag, win.len};
    end
  end

  a_ctrl_m_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
    ctrl_m_valid && !ctrl_m_ready |=> ctrl_m_valid && $stable(ctrl_m));

endmodule

`default_nettype wire

/* rtl/desc_fifo.sv */
//////////////////////////////
// Synchronous FWFT queue
// Head word is shown on dout, clear empties it
//////////////////////////////
`default_nettype none

module desc_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 64
) (
  input  logic             sys_clk,
  input  logic             sys_rst,
  input  logic             clear,
  input  logic [WIDTH-1:0] din,
  input  logic             din_valid,
  output logic             din_ready,
  output logic [WIDTH-1:0] dout,
  output logic             dout_valid,
  input  logic             dout_ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             push;
  logic             pop;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign din_ready  = (count != (AW + 1)'(DEPTH));
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];
  assign push       = din_valid && din_ready;
  assign pop        = dout_valid && dout_ready;

  always_ff @(posedge sys_clk) begin
    if (sys_rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      // Count only moves when exactly one side transfers
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge sys_clk) begin
    if (push) mem[wr_ptr] <= din;
  end

endmodule

`default_nettype wire

/* rtl/desc_hub_pkg.sv */
//////////////////////////////
// Descriptor hub shared types
// Descriptor, message and slot update formats
//////////////////////////////
`default_nettype none

package desc_hub_pkg;

  // Slot index width, taken from the low bits of a tag
  localparam int SLOT_W = 3;

  // Scheduler message type for the core reset command
  localparam logic [3:0] CTRL_RESET_TYPE = 4'hF;

  // Core descriptor opcodes
  typedef enum logic [3:0] {
    DESC_SEND      = 4'd0,
    DESC_SLOT_FREE = 4'd1,
    DESC_SLOT_BUSY = 4'd2,
    DESC_CORE_MSG  = 4'd3
  } desc_type_e;

  // Send path state
  typedef enum logic {
    IDLE,
    WAIT_SENT
  } send_state_e;

  typedef struct packed {
    logic [3:0]  desc_type;
    logic [11:0] rsvd;
    logic [15:0] addr;
    logic [7:0]  port;
    logic [7:0]  tag;
    logic [15:0] len;
  } desc_t;

  typedef struct packed {
    logic [3:0]  msg_type;
    logic [7:0]  port;
    logic [7:0]  tag;
    logic [15:0] len;
  } ctrl_msg_t;

  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
    logic [15:0]       addr;
    logic [15:0]       len;
  } slot_upd_t;

  typedef logic [45:0] bc_msg_t;
  typedef logic [3:0]  core_id_t;

endpackage

`default_nettype wire

/* rtl/sched_ctrl_parser.sv */
//////////////////////////////
// Scheduler control parser
// Reset command, slot table and scheduler send descriptors
//////////////////////////////
`default_nettype none

module sched_ctrl_parser #(
  parameter int          SLOT_COUNT     = 8,
  parameter logic [15:0] SLOT_BASE_ADDR = 16'h0,
  parameter logic [15:0] SLOT_ADDR_STEP = 16'h0800,
  parameter int          SEND_DEPTH     = 8
) (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  desc_hub_pkg::ctrl_msg_t  ctrl_s,
  input  logic                     ctrl_s_valid,
  output logic                     ctrl_s_ready,
  input  desc_hub_pkg::slot_upd_t  slot_upd,
  output desc_hub_pkg::desc_t      sched_send,
  output logic                     sched_send_valid,
  input  logic                     sched_send_ready,
  output logic                     core_reset
);

  import desc_hub_pkg::*;

  logic [15:0] slot_addr [SLOT_COUNT];
  // Per slot length, kept for the loopback path
  logic [15:0] slot_len  [SLOT_COUNT];

  ctrl_msg_t in_msg;
  logic      in_valid;
  logic      accept;
  logic      reset_acc;
  logic      core_reset_nxt;
  logic      push;
  logic      q_ready;
  desc_t     q_din;

  assign ctrl_s_ready   = !in_valid || q_ready;
  assign accept         = ctrl_s_valid && ctrl_s_ready;
  assign reset_acc      = accept && (ctrl_s.msg_type == CTRL_RESET_TYPE);
  assign core_reset_nxt = reset_acc ? ctrl_s.len[0] : core_reset;
  // Hold back the push when the core is or is about to be in reset
  assign push           = in_valid && !core_reset_nxt;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      core_reset <= 1'b1;
      in_valid   <= 1'b0;
    end else begin
      core_reset <= core_reset_nxt;
      in_valid   <= !core_reset_nxt &&
                    ((accept && !reset_acc) || (in_valid && !q_ready));
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept) in_msg <= ctrl_s;
  end

  ////////////////////////////////
  // Slot table
  ////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slot_addr[i] <= 16'(SLOT_BASE_ADDR + i * SLOT_ADDR_STEP);
      end
    end else if (slot_upd.valid) begin
      slot_addr[slot_upd.slot] <= slot_upd.addr;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (slot_upd.valid) slot_len[slot_upd.slot] <= slot_upd.len;
  end

  // Send descriptor, address looked up by the tag's slot
  always_comb begin
    q_din           = '0;
    q_din.desc_type = DESC_SEND;
    q_din.addr      = slot_addr[in_msg.tag[SLOT_W-1:0]];
    q_din.port      = in_msg.port;
    q_din.tag       = in_msg.tag;
    q_din.len       = in_msg.len;
  end

  desc_fifo #(.DEPTH(SEND_DEPTH), .WIDTH($bits(desc_t))) u_sched_q (
    .sys_clk, .sys_rst,
    .clear      (core_reset),
    .din        (q_din),
    .din_valid  (push),
    .din_ready  (q_ready),
    .dout       (sched_send),
    .dout_valid (sched_send_valid),
    .dout_ready (sched_send_ready)
  );

  a_no_send_in_reset: assert property (@(posedge sys_clk) disable iff (sys_rst)
    $rose(sched_send_valid) |-> !core_reset);

endmodule

`default_nettype wire

/* rtl/send_arbiter.sv */
//////////////////////////////
// Send arbiter
// One transmission in flight, completions go to the release queue
//////////////////////////////
`default_nettype none

module send_arbiter #(
  parameter int CTRL_DEPTH = 8
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  logic                 core_reset,
  input  desc_hub_pkg::desc_t  sched_send,
  input  logic                 sched_send_valid,
  output logic                 sched_send_ready,
  input  desc_hub_pkg::desc_t  core_send,
  input  logic                 core_send_valid,
  output logic                 core_send_ready,
  output desc_hub_pkg::desc_t  send_desc,
  output logic                 send_desc_valid,
  input  logic                 send_desc_ready,
  input  logic                 pkt_sent,
  output desc_hub_pkg::desc_t  released,
  output logic                 released_valid,
  input  logic                 released_ready
);

  import desc_hub_pkg::*;

  send_state_e state;
  desc_t       inflight;
  logic        rel_ready;
  logic        can_send;

  // Only offer a send when its release will have a place to go
  assign can_send        = (state == IDLE) && rel_ready;
  assign send_desc_valid = can_send && (sched_send_valid || core_send_valid);
  // Scheduler side wins
  assign send_desc       = sched_send_valid ? sched_send : core_send;

  assign sched_send_ready = can_send && send_desc_ready;
  assign core_send_ready  = can_send && send_desc_ready && !sched_send_valid;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:      if (send_desc_valid && send_desc_ready) state <= WAIT_SENT;
        WAIT_SENT: if (pkt_sent) state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (send_desc_valid && send_desc_ready) inflight <= send_desc;
  end

  desc_fifo #(.DEPTH(CTRL_DEPTH), .WIDTH($bits(desc_t))) u_release_q (
    .sys_clk, .sys_rst,
    .clear      (core_reset),
    .din        (inflight),
    .din_valid  ((state == WAIT_SENT) && pkt_sent),
    .din_ready  (rel_ready),
    .dout       (released),
    .dout_valid (released_valid),
    .dout_ready (released_ready)
  );

  a_sent_in_flight: assert property (@(posedge sys_clk) disable iff (sys_rst)
    pkt_sent |-> (state == WAIT_SENT));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the descriptor hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
